// File: compile.f
+incdir+tb
verilog/rv_decode_pkg.sv
verilog/op_decoder.sv
verilog/operand_former.sv
verilog/issue_control.sv
verilog/decode_stage_reg.sv
verilog/rv_decode.sv
tb/tb_rv_decode.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - verilog/rv_decode_pkg.sv
  - verilog/op_decoder.sv
  - verilog/operand_former.sv
  - verilog/issue_control.sv
  - verilog/decode_stage_reg.sv
  - verilog/rv_decode.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_rv_decode.sv

// File: tb/tb_rv_decode_model.svh
`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

logic [31:0]                           lfsr_state = 32'ha9bb;
logic [LOCK_DEPTH-1:0][REG_ADDR_W-1:0] lock_rd    = '0;  // Index 0 is the newest entry
logic [LOCK_DEPTH-1:0]                 lock_store = '0;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [31:0] bank_value(input logic [4:0] addr, input logic [31:0] salt);
    return salt ^ ({27'b0, addr} * 32'h0100_0193) ^ {addr, 27'b0};
endfunction

//////////////////////////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

//////////////////////////////////////////////////////////////////////
// Reference decode
//////////////////////////////////////////////////////////////////////

function automatic op_e ref_op(input logic [31:0] w);
    op_e        br_tab [8];
    op_e        ld_tab [8];
    op_e        st_tab [8];
    op_e        alu_tab [8];
    logic [2:0] f3;
    logic [6:0] f7;
    br_tab  = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    ld_tab  = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    st_tab  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    alu_tab = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};  // funct7 zero
    f3 = w[14:12];
    f7 = w[31:25];
    if (w == 32'h0000_0013) return NOP;
    case (w[6:0])
        OPC_LUI:    return LUI;
        OPC_AUIPC:  return ADD;
        OPC_JAL:    return JAL;
        OPC_JALR:   return (f3 == 3'b000) ? JALR : INVALID;
        OPC_BRANCH: return br_tab[f3];
        OPC_LOAD:   return ld_tab[f3];
        OPC_STORE:  return st_tab[f3];
        OPC_FENCE:  return (f3 == 3'b000) ? NOP : INVALID;
        OPC_OP_IMM: begin
            if (f3 != 3'b001 && f3 != 3'b101) return alu_tab[f3];  // funct7 is immediate
            if (f7 == 7'b0000000) return alu_tab[f3];
            return (f7 == 7'b0100000 && f3 == 3'b101) ? SRA : INVALID;
        end
        OPC_OP: begin
            if (f7 == 7'b0000000) return alu_tab[f3];
            if (f7 != 7'b0100000) return INVALID;
            return (f3 == 3'b000) ? SUB : (f3 == 3'b101) ? SRA : INVALID;
        end
        default: return INVALID;  // CSR and system space too
    endcase
endfunction

function automatic decode_out_s ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                           input logic [31:0] d1, input logic [31:0] d2);
    decode_out_s r;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    r.op        = ref_op(w);
    r.pc        = pc;
    r.exception = (r.op == INVALID);
    r.first_op  = d1;  // R format unless overridden below
    r.second_op = d2;
    r.third_op  = '0;
    case (w[6:0])
        OPC_OP_IMM, OPC_JALR, OPC_LOAD: begin
            r.second_op = imm_i;
            r.third_op  = imm_i;
        end
        OPC_STORE: begin
            r.second_op = imm_s;
            r.third_op  = d2;  // Store data
        end
        OPC_BRANCH: r.third_op = imm_b;
        OPC_LUI, OPC_AUIPC: begin
            r.first_op  = pc;
            r.second_op = imm_u;
            r.third_op  = imm_u;
        end
        OPC_JAL: begin
            r.first_op  = pc;
            r.second_op = imm_j;
            r.third_op  = imm_j;
        end
        default: ;
    endcase
    return r;
endfunction

//////////////////////////////////////////////////////////////////////
// Lock queue model
//////////////////////////////////////////////////////////////////////

function automatic logic model_hazard(input logic [31:0] w, input op_e op);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < LOCK_DEPTH; i++) begin
        if (w[19:15] != 5'd0 && lock_rd[i] == w[19:15]) hit = 1'b1;
        if (w[24:20] != 5'd0 && lock_rd[i] == w[24:20]) hit = 1'b1;
        if (lock_store[i] && op inside {LB, LH, LW, LBU, LHU, SB, SH, SW}) hit = 1'b1;
    end
    return hit;
endfunction

task automatic model_advance(input logic [31:0] w, input op_e op, input logic haz);
    logic writes;
    writes = op inside {LUI, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
                        JAL, JALR, LB, LH, LW, LBU, LHU};
    for (int i = LOCK_DEPTH - 1; i > 0; i--) begin
        lock_rd[i]    = lock_rd[i-1];
        lock_store[i] = lock_store[i-1];
    end
    lock_rd[0]    = (!haz && writes) ? w[11:7] : 5'd0;  // Bubble locks nothing
    lock_store[0] = !haz && (op inside {SB, SH, SW});
endtask

`endif

// File: tb/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode import rv_decode_pkg::*; ();

    localparam int LOCK_DEPTH   = 2;
    localparam int N_RANDOM     = 48;
    localparam int N_PAIRS      = 4;
    localparam int N_ILLEGAL    = 8;
    localparam int STALL_CYCLES = 4;
    localparam int N_ISSUES     = 1 + N_RANDOM + N_PAIRS * (LOCK_DEPTH + 2) + (LOCK_DEPTH + 2)
                                  + 3 + N_ILLEGAL + (LOCK_DEPTH + 4);
    localparam int CYCLE_LIMIT  = 2 + N_ISSUES * (LOCK_DEPTH + 1) + STALL_CYCLES + 12 + 40;

    localparam decode_out_s NOP_RESULT = '{op: NOP, default: '0};

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  stall_i;
    instr_u                instruction_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       regbank_data1_i;
    logic [XLEN-1:0]       regbank_data2_i;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic [REG_ADDR_W-1:0] rd_o;
    logic                  hazard_o;
    decode_out_s           result_o;

    int          cycles       = 0;
    int          checks       = 0;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] bank_salt    = '0;
    decode_out_s expected_q[$];
    decode_out_s last_expected = NOP_RESULT;  // What the stage register holds

    `include "tb_rv_decode_model.svh"

    rv_decode #(.LOCK_DEPTH(LOCK_DEPTH)) DUT (.*);

    always #10 clk = ~clk;

    // Combinational register bank
    assign regbank_data1_i = bank_value(rs1_o, bank_salt);
    assign regbank_data2_i = bank_value(rs2_o, bank_salt);

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a test stopped making progress", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and compare process
    //////////////////////////////////////////////////////////////////////

    task automatic check_result(input decode_out_s got, input decode_out_s exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] result_o: got %h (%s), expected %h (%s)",
                     got, got.op.name(), exp, exp.op.name());
        end
    endtask

    task automatic check_hazard(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] hazard_o: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
                             input logic [REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Result of the previous cycle is stable on the falling edge
    always @(negedge clk) begin
        if (expected_q.size() > 0) check_result(result_o, expected_q.pop_front());
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Holds the word until a cycle with neither stall nor hazard
    task automatic issue(input logic [31:0] word, input logic [31:0] pc,
                         input int stall_cycles, output int bubbles);
        decode_out_s exp;
        logic        haz;
        logic        stalled;
        int          cyc;
        bubbles = 0;
        cyc     = 0;
        do begin
            stalled = (cyc < stall_cycles);
            @(negedge clk);
            instruction_i = word;
            pc_i          = pc;
            stall_i       = stalled;
            #5;
            exp = ref_decode(word, pc, bank_value(word[19:15], bank_salt),
                             bank_value(word[24:20], bank_salt));
            haz = model_hazard(word, exp.op);
            check_hazard(hazard_o, haz);
            check_reg("rs1_o", rs1_o, word[19:15]);
            check_reg("rs2_o", rs2_o, word[24:20]);
            check_reg("rd_o", rd_o, lock_rd[LOCK_DEPTH-1]);
            if (!stalled) begin
                model_advance(word, exp.op, haz);
                last_expected = haz ? NOP_RESULT : exp;
                if (haz) bubbles++;
            end
            expected_q.push_back(last_expected);
            cyc++;
        end while (stalled || haz);
    endtask

    task automatic flush();
        int bubbles;
        for (int i = 0; i < LOCK_DEPTH; i++) begin
            issue(NOP_WORD, 32'h0, 0, bubbles);
        end
    endtask

    task automatic drain();
        while (expected_q.size() > 0) begin
            @(negedge clk);
            instruction_i = NOP_WORD;  // Idle word, frozen by stall
            stall_i       = 1'b1;
            #1;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        drain();
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] random_instr(input int sel);
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] imm;
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        f3  = 3'(rand_bits(3));
        imm = rand_bits(32);
        case (sel % 8)  // Every format, rd always x0
            0:       return enc_r(imm[0] ? F7_ALT : F7_BASE, rs2, rs1, f3, 5'd0, OPC_OP);
            1:       return enc_i(imm[11:0], rs1, f3, 5'd0, OPC_OP_IMM);
            2:       return enc_i(imm[11:0], rs1, f3, 5'd0, OPC_LOAD);
            3:       return enc_s(imm[11:0], rs2, rs1, f3);
            4:       return enc_b(imm[12:0], rs2, rs1, f3);
            5:       return enc_u(imm[19:0], 5'd0, imm[31] ? OPC_AUIPC : OPC_LUI);
            6:       return enc_j(imm[20:0], 5'd0);
            default: return enc_i(imm[11:0], rs1, 3'b000, 5'd0, OPC_JALR);
        endcase
    endfunction

    initial begin
        int          bubbles;
        int          errs;
        logic [31:0] word;
        logic [31:0] pc;
        logic [4:0]  reg_n;
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = NOP_WORD;
        pc_i          = '0;
        bank_salt     = rand_bits(32);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        errs = errors;
        check_result(result_o, NOP_RESULT);
        check_reg("rd_o", rd_o, '0);
        issue(NOP_WORD, 32'h0, 0, bubbles);
        end_test("reset state", errs);

        errs = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            word = random_instr(i);
            pc   = {rand_bits(30), 2'b00};
            issue(word, pc, 0, bubbles);
        end
        end_test("random decode", errs);

        errs = errors;
        for (int n = 0; n < N_PAIRS; n++) begin
            reg_n = 5'(1 + 10 * n);  // x1 x11 x21 x31
            flush();
            issue(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, reg_n, OPC_OP_IMM), 32'h100, 0,
                  bubbles);
            issue(enc_r(F7_BASE, 5'd0, reg_n, 3'b000, 5'd0, OPC_OP), 32'h104, 0, bubbles);
            if (bubbles != LOCK_DEPTH) begin
                errors++;
                $display("Reader of x%0d saw %0d bubbles instead of %0d",
                         reg_n, bubbles, LOCK_DEPTH);
            end
        end
        end_test("read after write", errs);

        errs = errors;
        flush();
        issue(enc_s(12'h024, 5'd0, 5'd0, 3'b010), 32'h200, 0, bubbles);
        issue(enc_i(12'h024, 5'd0, 3'b010, 5'd7, OPC_LOAD), 32'h204, 0, bubbles);
        if (bubbles != LOCK_DEPTH) begin
            errors++;
            $display("Load after store saw %0d bubbles instead of %0d", bubbles, LOCK_DEPTH);
        end
        end_test("load after store", errs);

        errs = errors;
        issue({12'h300, 5'd2, 3'b001, 5'd0, 7'b1110011}, 32'h300, 0, bubbles);  // csrrw
        issue(32'h0000_0073, 32'h304, 0, bubbles);  // ecall
        issue(32'h3020_0073, 32'h308, 0, bubbles);  // mret
        for (int i = 0; i < N_ILLEGAL; i++) begin
            if (i % 2 == 0) word = {rand_bits(25), 7'b0001011};  // Custom-0 opcode
            else word = {7'b1111111, rand_bits(18), OPC_OP};
            issue(word, 32'h30c + 4 * i, 0, bubbles);
        end
        end_test("illegal words", errs);

        errs = errors;
        flush();
        for (int i = 0; i < 4; i++) begin
            if (i == 0) word = enc_i(12'h001, 5'd0, 3'b000, 5'd9, OPC_OP_IMM);  // Locks x9
            else word = random_instr(i + 1);
            issue(word, 32'h400 + 4 * i, (i == 1) ? STALL_CYCLES : 0, bubbles);
        end
        end_test("stall hold", errs);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_decode_pkg::*; #(
    parameter int LOCK_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  instr_u                instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       regbank_data1_i,
    input  logic [XLEN-1:0]       regbank_data2_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  hazard_o,
    output decode_out_s           result_o
);

    instr_u          cur_instr;  // Replayed or fresh word
    op_e             op;
    logic [XLEN-1:0] first_op;
    logic [XLEN-1:0] second_op;
    logic [XLEN-1:0] third_op;

    issue_control #(
        .LOCK_DEPTH (LOCK_DEPTH)
    ) u_issue_control (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .op_i          (op),
        .cur_instr_o   (cur_instr),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    op_decoder u_op_decoder (
        .instr_i (cur_instr),
        .op_o    (op)
    );

    operand_former u_operand_former (
        .instr_i         (cur_instr),
        .pc_i            (pc_i),
        .regbank_data1_i (regbank_data1_i),
        .regbank_data2_i (regbank_data2_i),
        .first_op_o      (first_op),
        .second_op_o     (second_op),
        .third_op_o      (third_op)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .hazard_i    (hazard_o),
        .op_i        (op),
        .first_op_i  (first_op),
        .second_op_i (second_op),
        .third_op_i  (third_op),
        .pc_i        (pc_i),
        .result_o    (result_o)
    );

endmodule

// File: verilog/decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic            hazard_i,
    input  op_e             op_i,
    input  logic [XLEN-1:0] first_op_i,
    input  logic [XLEN-1:0] second_op_i,
    input  logic [XLEN-1:0] third_op_i,
    input  logic [XLEN-1:0] pc_i,
    output decode_out_s     result_o
);

    decode_out_s next_result;

    always_comb begin
        next_result.op        = op_i;
        next_result.first_op  = first_op_i;
        next_result.second_op = second_op_i;
        next_result.third_op  = third_op_i;
        next_result.pc        = pc_i;
        next_result.exception = (op_i == INVALID);  // Undecodable word
    end

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            result_o <= DECODE_BUBBLE;
        end else if (!stall_i) begin
            result_o <= hazard_i ? DECODE_BUBBLE : next_result;  // Hold while stalled
        end
    end

    a_hazard_bubble: assert property (@(posedge clk) disable iff (reset)
        hazard_i && !stall_i |=> result_o.op == NOP && !result_o.exception);

endmodule

// File: verilog/issue_control.sv
`timescale 1ns/1ps

module issue_control import rv_decode_pkg::*; #(
    parameter int LOCK_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  instr_u                instruction_i,
    input  op_e                   op_i,           // Operation of cur_instr_o
    output instr_u                cur_instr_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,           // Oldest queue entry
    output logic                  hazard_o
);

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  store;
    } lock_entry_s;

    lock_entry_s [LOCK_DEPTH-1:0] lock_q;
    lock_entry_s                  push_entry;
    instr_u                       last_instr;
    logic                         last_hazard;
    logic                         reg_hit;
    logic                         mem_busy;
    logic                         writes_rd;
    logic                         is_store;

    //////////////////////////////////////////////////////////////////////
    // Replay of the held instruction
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= cur_instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
        end
    end

    assign cur_instr_o = last_hazard ? last_instr : instruction_i;
    assign rs1_o       = cur_instr_o.r.rs1;
    assign rs2_o       = cur_instr_o.r.rs2;

    //////////////////////////////////////////////////////////////////////
    // Hazard detection against the lock queue
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_hit  = 1'b0;
        mem_busy = 1'b0;
        for (int i = 0; i < LOCK_DEPTH; i++) begin
            reg_hit  |= (rs1_o != '0 && lock_q[i].rd == rs1_o) ||
                        (rs2_o != '0 && lock_q[i].rd == rs2_o);
            mem_busy |= lock_q[i].store;
        end
    end

    assign hazard_o = reg_hit || (mem_busy && exec_unit_e'(op_i[5:3]) == MEMORY);

    assign is_store = op_i inside {SB, SH, SW};

    always_comb begin
        case (exec_unit_e'(op_i[5:3]))
            ADDER, LOGICAL, SHIFTER: writes_rd = 1'b1;
            BRANCH:                  writes_rd = (op_i == JAL) || (op_i == JALR);
            MEMORY:                  writes_rd = !is_store;
            default:                 writes_rd = (op_i == LUI);  // NOP, INVALID write nothing
        endcase
    end

    // A bubble locks nothing
    assign push_entry.rd    = (hazard_o || !writes_rd) ? '0 : cur_instr_o.r.rd;
    assign push_entry.store = !hazard_o && is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q <= '0;
        end else if (!stall_i) begin
            lock_q[0] <= push_entry;
            for (int i = 1; i < LOCK_DEPTH; i++) begin
                lock_q[i] <= lock_q[i-1];
            end
        end
    end

    assign rd_o = lock_q[LOCK_DEPTH-1].rd;

    a_bubble_push: assert property (@(posedge clk) disable iff (reset)
        hazard_o && !stall_i |=> lock_q[0] == '0);

endmodule

// File: verilog/operand_former.sv
`timescale 1ns/1ps

module operand_former import rv_decode_pkg::*; (
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] regbank_data1_i,  // Answers rs1 this cycle
    input  logic [XLEN-1:0] regbank_data2_i,  // Answers rs2 this cycle
    output logic [XLEN-1:0] first_op_o,
    output logic [XLEN-1:0] second_op_o,
    output logic [XLEN-1:0] third_op_o
);

    fmt_e            fmt;
    logic [XLEN-1:0] imm;
    logic            sign;

    assign sign = instr_i.s.imm_hi[6];  // Bit 31 in every format

    //////////////////////////////////////////////////////////////////////
    // Format from the major opcode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (instr_i.s.opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: fmt = I_TYPE;
            OPC_STORE:                      fmt = S_TYPE;
            OPC_BRANCH:                     fmt = B_TYPE;
            OPC_LUI, OPC_AUIPC:             fmt = U_TYPE;
            OPC_JAL:                        fmt = J_TYPE;
            default:                        fmt = R_TYPE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Immediate assembly
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (fmt)
            I_TYPE:  imm = {{20{sign}}, instr_i.s.imm_hi, instr_i.s.rs2};
            S_TYPE:  imm = {{20{sign}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            B_TYPE:  imm = {{19{sign}}, sign, instr_i.s.imm_lo[0],
                            instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
            U_TYPE:  imm = {instr_i.s.imm_hi, instr_i.s.rs2, instr_i.s.rs1,
                            instr_i.s.funct3, 12'b0};
            J_TYPE:  imm = {{11{sign}}, sign, instr_i.s.rs1, instr_i.s.funct3,
                            instr_i.s.rs2[0], instr_i.s.imm_hi[5:0],
                            instr_i.s.rs2[4:1], 1'b0};
            default: imm = '0;  // R format has none
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    assign first_op_o = (fmt == U_TYPE || fmt == J_TYPE) ? pc_i : regbank_data1_i;

    assign second_op_o = (fmt == R_TYPE || fmt == B_TYPE) ? regbank_data2_i : imm;

    // Store data rides here, branch offset otherwise
    assign third_op_o = (fmt == S_TYPE) ? regbank_data2_i : imm;

endmodule

// File: verilog/op_decoder.sv
`timescale 1ns/1ps

module op_decoder import rv_decode_pkg::*; (
    input  instr_u instr_i,  // Word being decoded
    output op_e    op_o
);

    always_comb begin
        op_o = INVALID;  // Anything left unmatched
        case (instr_i.r.opcode)
            OPC_LUI:   op_o = LUI;
            OPC_AUIPC: op_o = ADD;  // PC plus upper immediate
            OPC_JAL:   op_o = JAL;
            OPC_JALR: begin
                if (instr_i.r.funct3 == 3'b000) op_o = JALR;
            end
            OPC_BRANCH: begin
                case (instr_i.r.funct3)
                    3'b000:  op_o = BEQ;
                    3'b001:  op_o = BNE;
                    3'b100:  op_o = BLT;
                    3'b101:  op_o = BGE;
                    3'b110:  op_o = BLTU;
                    3'b111:  op_o = BGEU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (instr_i.r.funct3)
                    3'b000:  op_o = LB;
                    3'b001:  op_o = LH;
                    3'b010:  op_o = LW;
                    3'b100:  op_o = LBU;
                    3'b101:  op_o = LHU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_STORE: begin
                case (instr_i.r.funct3)
                    3'b000:  op_o = SB;
                    3'b001:  op_o = SH;
                    3'b010:  op_o = SW;
                    default: op_o = INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                case ({instr_i.r.funct7, instr_i.r.funct3}) inside
                    {7'b???????, 3'b000}: op_o = ADD;
                    {7'b???????, 3'b010}: op_o = SLT;
                    {7'b???????, 3'b011}: op_o = SLTU;
                    {7'b???????, 3'b100}: op_o = XOR;
                    {7'b???????, 3'b110}: op_o = OR;
                    {7'b???????, 3'b111}: op_o = AND;
                    {F7_BASE, 3'b001}:    op_o = SLL;  // Shamt lives in rs2 field
                    {F7_BASE, 3'b101}:    op_o = SRL;
                    {F7_ALT, 3'b101}:     op_o = SRA;
                    default:              op_o = INVALID;
                endcase
            end
            OPC_OP: begin
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {F7_BASE, 3'b000}: op_o = ADD;
                    {F7_ALT, 3'b000}:  op_o = SUB;
                    {F7_BASE, 3'b001}: op_o = SLL;
                    {F7_BASE, 3'b010}: op_o = SLT;
                    {F7_BASE, 3'b011}: op_o = SLTU;
                    {F7_BASE, 3'b100}: op_o = XOR;
                    {F7_BASE, 3'b101}: op_o = SRL;
                    {F7_ALT, 3'b101}:  op_o = SRA;
                    {F7_BASE, 3'b110}: op_o = OR;
                    {F7_BASE, 3'b111}: op_o = AND;
                    default:           op_o = INVALID;
                endcase
            end
            OPC_FENCE: begin
                if (instr_i.r.funct3 == 3'b000) op_o = NOP;  // No memory ordering to do here
            end
            default: op_o = INVALID;  // System and CSR space lands here too
        endcase
        if (instr_i.r == NOP_WORD) op_o = NOP;
    end

    // Even an X word must fall through to a defined operation
    a_op_known: assert final (!$isunknown(op_o));

endmodule

// File: verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    localparam logic [6:0]      F7_BASE  = 7'b0000000;
    localparam logic [6:0]      F7_ALT   = 7'b0100000;  // SUB and SRA(I)
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [2:0] {
        BYPASS  = 3'd0,
        ADDER   = 3'd1,
        LOGICAL = 3'd2,
        SHIFTER = 3'd3,
        BRANCH  = 3'd4,
        MEMORY  = 3'd5
    } exec_unit_e;

    // First octal digit is the execution unit
    typedef enum logic [5:0] {
        NOP  = 6'o00, LUI  = 6'o01, INVALID = 6'o07,
        ADD  = 6'o10, SUB  = 6'o11, SLT  = 6'o12, SLTU = 6'o13,
        XOR  = 6'o20, OR   = 6'o21, AND  = 6'o22,
        SLL  = 6'o30, SRL  = 6'o31, SRA  = 6'o32,
        BEQ  = 6'o40, BNE  = 6'o41, BLT  = 6'o42, BGE  = 6'o43,
        BLTU = 6'o44, BGEU = 6'o45, JAL  = 6'o46, JALR = 6'o47,
        LB   = 6'o50, LH   = 6'o51, LW   = 6'o52, LBU  = 6'o53,
        LHU  = 6'o54, SB   = 6'o55, SH   = 6'o56, SW   = 6'o57
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } fmt_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_s;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } instr_s_s;

    typedef union packed {
        instr_r_s r;  // Register fields
        instr_s_s s;  // Split immediate fields
    } instr_u;

    typedef struct packed {
        op_e             op;
        logic [XLEN-1:0] first_op;
        logic [XLEN-1:0] second_op;
        logic [XLEN-1:0] third_op;
        logic [XLEN-1:0] pc;
        logic            exception;
    } decode_out_s;

    localparam decode_out_s DECODE_BUBBLE = '{
        op: NOP, first_op: '0, second_op: '0, third_op: '0, pc: '0, exception: 1'b0
    };

endpackage
